// File: build.f
+incdir+include
src/c16_mem_pkg.sv
src/prg_loader.sv
src/main_ram.sv
src/rom_bank_ctrl.sv
src/rom_store.sv
src/c16_memory_top.sv
tb/c16_mem_model.sv
tb/tb_c16_memory.sv

// File: Makefile
# Verilator simulation of the C16/Plus4 memory testbench

VERILATOR ?= verilator
TOP       ?= tb_c16_memory
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= TEST PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_c16_memory.sv
// Plays the host and the CPU bus; each read is compared one clock later with the reference model
`default_nettype none

`include "c16_settings.svh"

module tb_c16_memory
	import c16_mem_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int SEED       = 32'h6a97_9ea1;
	localparam int ROM_BYTES  = `C16_ROM_DEPTH;
	localparam int RAM_OPS    = 150;
	localparam int BANK_OPS   = 100;
	// Watchdog budget in clocks
	localparam int DL_CYCLES  = 6 * ROM_BYTES + 202 + 64;
	localparam int BUS_CYCLES = 2000 + RAM_OPS * 6 + BANK_OPS * 20;
	localparam int TIME_LIMIT = (DL_CYCLES + BUS_CYCLES + 2000) * CLK_PERIOD;
	localparam cpu_addr_t PTR_ADDRS [8] = '{16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h009D, 16'h009E};

	logic      clk_sys;
	logic      reset;
	logic      model_i;
	dl_port_t  dl;
	cpu_bus_t  cpu;
	byte_t     cpu_din;
	byte_t     exp_din;
	int        seed_val;
	cpu_addr_t ram_addrs[$];

	c16_memory_top DUT (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.model_i   (model_i),
		.dl_i      (dl),
		.cpu_i     (cpu),
		.cpu_din_o (cpu_din)
	);

	c16_mem_model u_model (
		.clk_sys (clk_sys),
		.reset   (reset),
		.model_i (model_i),
		.dl_i    (dl),
		.cpu_i   (cpu),
		.exp_o   (exp_din)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	////////////////////////////////////////
	// Bus and download helpers
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic bus_idle();
		cpu.addr     = '0;
		cpu.data     = '0;
		cpu.rnw      = 1'b1;
		cpu.cs_ram_n = 1'b1;
		cpu.cs0_n    = 1'b1;
		cpu.cs1_n    = 1'b1;
		cpu.cs_io_n  = 1'b1;
	endtask

	function automatic cpu_addr_t rand_addr(input cpu_addr_t lo, input cpu_addr_t hi);
		return cpu_addr_t'($urandom_range(hi, lo));
	endfunction

	// Registered byte is out one clock after the select
	task automatic read_check(input cpu_addr_t addr, input logic ram_n,
		input logic rom0_n, input logic rom1_n);
		bus_idle();
		cpu.addr     = addr;
		cpu.cs_ram_n = ram_n;
		cpu.cs0_n    = rom0_n;
		cpu.cs1_n    = rom1_n;
		next_cycle();
		assert (!$isunknown(exp_din) && cpu_din === exp_din) else begin
			$display("Mismatch at %0t: address %h read %h, expected %h",
				$time, addr, cpu_din, exp_din);
			$display("TEST FAILED");
			$fatal(1, "Read data differs from the model");
		end
	endtask

	// Select held two clocks so the RAM takes the byte in the second
	task automatic ram_write(input cpu_addr_t addr, input byte_t data);
		bus_idle();
		next_cycle();
		cpu.addr     = addr;
		cpu.data     = data;
		cpu.rnw      = 1'b0;
		cpu.cs_ram_n = 1'b0;
		repeat (2) next_cycle();
		bus_idle();
	endtask

	task automatic bank_write(input logic [1:0] lo, input logic [1:0] hi);
		bus_idle();
		next_cycle();
		cpu.addr    = {`C16_BANK_IO_PAGE, hi, lo};
		cpu.rnw     = 1'b0;
		cpu.cs_io_n = 1'b0;
		next_cycle();
		bus_idle();
	endtask

	task automatic download(input byte_t index, input dl_addr_t start, input int count,
		input cpu_addr_t load);
		dl.download = 1'b1;
		dl.index    = index;
		for (int i = 0; i < count; i++) begin
			dl.wr   = 1'b1;
			dl.addr = start + dl_addr_t'(i);
			dl.data = byte_t'($urandom);
			if (index == `C16_DL_PRG && i < 2)
				dl.data = (i == 0) ? load[7:0] : load[15:8];
			next_cycle();
		end
		dl.wr       = 1'b0;
		dl.download = 1'b0;
		next_cycle();
	endtask

	////////////////////////////////////////
	// Test sequence
	initial begin
		cpu_addr_t addr;
		int        len;
		seed_val = $urandom(SEED);
		clk_sys  = 1'b0;
		reset    = 1'b1;
		model_i  = 1'b1;
		dl       = '0;
		bus_idle();
		repeat (3) next_cycle();
		reset = 1'b0;

		// System ROMs with the banks at reset
		for (int b = `C16_DL_BANK_KERNAL; b <= `C16_DL_BANK_FUNC_H; b++)
			download(`C16_DL_ROM, dl_addr_t'(b) << `C16_ROM_AW, ROM_BYTES, '0);
		repeat (100) begin
			read_check(rand_addr(16'h8000, 16'hBFFF), 1'b1, 1'b0, 1'b1);
			read_check(rand_addr(16'hC000, 16'hFFFF), 1'b1, 1'b1, 1'b0);
			read_check(rand_addr(16'h0000, 16'hFFFF), 1'b1, 1'b1, 1'b1);
		end

		// PRG program and its end pointers
		addr = rand_addr(16'h1000, 16'h7000);
		len  = $urandom_range(200, 20);
		download(`C16_DL_PRG, '0, len + 2, addr);
		for (int i = 0; i < len; i++)
			read_check(addr + cpu_addr_t'(i), 1'b0, 1'b1, 1'b1);
		repeat (16) next_cycle();
		foreach (PTR_ADDRS[i])
			read_check(PTR_ADDRS[i], 1'b0, 1'b1, 1'b1);

		// CPU RAM traffic in a small window so addresses repeat
		repeat (RAM_OPS) begin
			addr = rand_addr(16'hA000, 16'hA03F);
			ram_write(addr, byte_t'($urandom));
			ram_addrs.push_back(addr);
			read_check(ram_addrs[$urandom_range(ram_addrs.size() - 1, 0)],
				1'b0, 1'b1, 1'b1);
		end
		foreach (ram_addrs[i])
			read_check(ram_addrs[i], 1'b0, 1'b1, 1'b1);

		// Plus/4 bank register before any cartridge is loaded
		repeat (BANK_OPS) begin
			bank_write(2'($urandom), 2'($urandom));
			read_check(rand_addr(16'h8000, 16'hBFFF), 1'b1, 1'b0, 1'b1);
			read_check(rand_addr(16'hC000, 16'hFBFF), 1'b1, 1'b1, 1'b0);
			read_check(rand_addr(16'hFC00, 16'hFCFF), 1'b1, 1'b1, 1'b0);
		end

		// Cartridge download puts both banks back to internal
		bank_write(BANK_FUNC, BANK_FUNC);
		download(`C16_DL_CRT, '0, 2 * ROM_BYTES, '0);
		repeat (50) begin
			read_check(rand_addr(16'h8000, 16'hBFFF), 1'b1, 1'b0, 1'b1);
			read_check(rand_addr(16'hC000, 16'hFFFF), 1'b1, 1'b1, 1'b0);
		end
		bank_write(BANK_CART, BANK_CART);
		repeat (100) begin
			read_check(rand_addr(16'h8000, 16'hBFFF), 1'b1, 1'b0, 1'b1);
			read_check(rand_addr(16'hC000, 16'hFBFF), 1'b1, 1'b1, 1'b0);
		end

		// C16 model ignores the bank register
		model_i = 1'b0;
		reset   = 1'b1;
		repeat (3) next_cycle();
		reset = 1'b0;
		repeat (BANK_OPS) begin
			bank_write(2'($urandom), 2'($urandom));
			read_check(rand_addr(16'h8000, 16'hBFFF), 1'b1, 1'b0, 1'b1);
			read_check(rand_addr(16'hC000, 16'hFBFF), 1'b1, 1'b1, 1'b0);
		end

		$display("TEST PASSED");
		$finish;
	end

	////////////////////////////////////////
	// Watchdog
	initial begin
		#(TIME_LIMIT);
		$display("Timeout: the run did not finish within %0d time units", TIME_LIMIT);
		$display("TEST FAILED");
		$fatal(1, "Watchdog expired");
	end

endmodule

`default_nettype wire

// File: tb/c16_mem_model.sv
// Reference memory map; a read must not hit a byte written in the same clock, unloaded ROM bytes are X
`default_nettype none

`include "c16_settings.svh"

module c16_mem_model
	import c16_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     model_i,
	input  dl_port_t dl_i,
	input  cpu_bus_t cpu_i,
	output byte_t    exp_o
);

	byte_t     ram [`C16_RAM_DEPTH];
	byte_t     rom [`C16_ROM_COUNT][`C16_ROM_DEPTH];
	logic      plus4;
	logic      cart_l;
	logic      cart_h;
	logic      io_n_old;
	logic      ram_n_old;
	logic      dl_old;
	rom_bank_e bank_lo;
	rom_bank_e bank_hi;
	cpu_addr_t load_addr;
	cpu_addr_t end_addr;

	// Byte of one ROM, a negative index means nothing drives
	function automatic byte_t rom_byte(input int idx, input cpu_addr_t addr);
		if (idx < 0)
			return 8'hFF;
		return rom[idx][addr[`C16_ROM_AW-1:0]];
	endfunction

	function automatic byte_t predict(input cpu_bus_t b);
		byte_t v;
		int    lo_src;
		int    hi_src;
		v = 8'hFF;
		if (!b.cs_ram_n)
			v = v & ram[b.addr];
		case (bank_lo)
			BANK_INTERNAL: lo_src = `C16_ROM_BASIC;
			BANK_CART:     lo_src = cart_l ? `C16_ROM_CART_L : -1;
			BANK_FUNC:     lo_src = `C16_ROM_FUNC_L;
			default:       lo_src = -1;
		endcase
		case (bank_hi)
			BANK_INTERNAL: hi_src = `C16_ROM_KERNAL;
			BANK_CART:     hi_src = cart_h ? `C16_ROM_CART_H : -1;
			BANK_FUNC:     hi_src = `C16_ROM_FUNC_H;
			default:       hi_src = -1;
		endcase
		if (b.addr[15:8] == `C16_KERN_PAGE)
			hi_src = `C16_ROM_KERNAL;
		if (!b.cs0_n)
			v = v & rom_byte(lo_src, b.addr);
		if (!b.cs1_n)
			v = v & rom_byte(hi_src, b.addr);
		return v;
	endfunction

	task automatic take_download();
		int bank;
		int ofs;
		bank = int'(dl_i.addr[`C16_DL_AW-1:`C16_ROM_AW]);
		ofs  = int'(dl_i.addr[`C16_ROM_AW-1:0]);
		if (dl_i.index == `C16_DL_ROM) begin
			case (bank)
				`C16_DL_BANK_KERNAL: rom[`C16_ROM_KERNAL][ofs] = dl_i.data;
				`C16_DL_BANK_BASIC:  rom[`C16_ROM_BASIC][ofs] = dl_i.data;
				`C16_DL_BANK_FUNC_L: rom[`C16_ROM_FUNC_L][ofs] = dl_i.data;
				`C16_DL_BANK_FUNC_H: rom[`C16_ROM_FUNC_H][ofs] = dl_i.data;
				default: ;
			endcase
		end else if (dl_i.index == `C16_DL_CRT) begin
			if (bank == `C16_DL_BANK_CART_L) begin
				rom[`C16_ROM_CART_L][ofs] = dl_i.data;
				cart_l = 1'b1;
			end else if (bank == `C16_DL_BANK_CART_H) begin
				rom[`C16_ROM_CART_H][ofs] = dl_i.data;
				cart_h = 1'b1;
			end
		end else if (dl_i.index == `C16_DL_PRG && dl_i.download) begin
			// Two header bytes give the load address, low byte first
			if (dl_i.addr == 0)
				load_addr[7:0] = dl_i.data;
			else if (dl_i.addr == 1)
				load_addr[15:8] = dl_i.data;
			else begin
				ram[load_addr + cpu_addr_t'(dl_i.addr - 2)] = dl_i.data;
				end_addr = load_addr + cpu_addr_t'(dl_i.addr - 1);
			end
		end
	endtask

	// BASIC end pointers
	task automatic patch_end_pointers();
		ram[16'h002D] = end_addr[7:0];
		ram[16'h002F] = end_addr[7:0];
		ram[16'h0031] = end_addr[7:0];
		ram[16'h009D] = end_addr[7:0];
		ram[16'h002E] = end_addr[15:8];
		ram[16'h0030] = end_addr[15:8];
		ram[16'h0032] = end_addr[15:8];
		ram[16'h009E] = end_addr[15:8];
	endtask

	always @(posedge clk_sys) begin
		// Read byte comes from the state before this clock
		exp_o <= predict(cpu_i);
		if (reset) begin
			plus4     = model_i;
			bank_lo   = BANK_INTERNAL;
			bank_hi   = BANK_INTERNAL;
			cart_l    = 1'b0;
			cart_h    = 1'b0;
			io_n_old  = 1'b1;
			ram_n_old = 1'b1;
			dl_old    = 1'b0;
		end else begin
			if (ram_n_old && !cpu_i.cs_ram_n && !cpu_i.rnw)
				ram[cpu_i.addr] = cpu_i.data;
			if (plus4 && dl_i.download && dl_i.index == `C16_DL_CRT) begin
				bank_lo = BANK_INTERNAL;
				bank_hi = BANK_INTERNAL;
			end else if (plus4 && io_n_old && !cpu_i.cs_io_n && !cpu_i.rnw &&
				cpu_i.addr[15:4] == `C16_BANK_IO_PAGE) begin
				bank_lo = rom_bank_e'(cpu_i.addr[1:0]);
				bank_hi = rom_bank_e'(cpu_i.addr[3:2]);
			end
			if (dl_i.wr)
				take_download();
			if (dl_old && !dl_i.download && dl_i.index == `C16_DL_PRG)
				patch_end_pointers();
			io_n_old  = cpu_i.cs_io_n;
			ram_n_old = cpu_i.cs_ram_n;
			dl_old    = dl_i.download;
		end
	end

endmodule

`default_nettype wire

// File: src/c16_memory_top.sv
// CPU core is external; read data is valid one clock after address and select are applied
`default_nettype none

module c16_memory_top
	import c16_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     model_i,
	input  dl_port_t dl_i,
	input  cpu_bus_t cpu_i,
	output byte_t    cpu_din_o
);

	logic      ram_wr;
	cpu_addr_t ram_addr;
	byte_t     ram_data;
	byte_t     ram_dout;
	byte_t     rom_dout;
	rom_sel_t  rom_sel;

	//////////////// RAM ///////////////////
	prg_loader u_prg_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_i       (dl_i),
		.ram_wr_o   (ram_wr),
		.ram_addr_o (ram_addr),
		.ram_data_o (ram_data)
	);

	main_ram u_main_ram (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ram_wr_i   (ram_wr),
		.ram_addr_i (ram_addr),
		.ram_data_i (ram_data),
		.cpu_i      (cpu_i),
		.dout_o     (ram_dout)
	);

	//////////////// ROM ///////////////////
	rom_bank_ctrl u_rom_bank_ctrl (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.model_i   (model_i),
		.dl_i      (dl_i),
		.cpu_i     (cpu_i),
		.rom_sel_o (rom_sel)
	);

	rom_store u_rom_store (
		.clk_sys    (clk_sys),
		.dl_i       (dl_i),
		.cpu_addr_i (cpu_i.addr),
		.rom_sel_i  (rom_sel),
		.dout_o     (rom_dout)
	);

	// Idle sources drive FF so the bytes combine by AND
	assign cpu_din_o = ram_dout & rom_dout;

endmodule

`default_nettype wire

// File: src/rom_store.sv
// ROM contents are undefined until downloaded; unselected ROMs read as all ones
`default_nettype none

`include "c16_settings.svh"

module rom_store
	import c16_mem_pkg::*;
(
	input  logic      clk_sys,
	input  dl_port_t  dl_i,
	input  cpu_addr_t cpu_addr_i,
	input  rom_sel_t  rom_sel_i,
	output byte_t     dout_o
);

	logic [`C16_DL_AW-`C16_ROM_AW-1:0] dl_bank;
	logic      is_rom;
	logic      is_crt;
	rom_sel_t  wr_sel;
	rom_addr_t wr_addr;
	rom_addr_t rd_addr;
	wire [`C16_ROM_COUNT*8-1:0] rom_q_all;

	assign dl_bank = dl_i.addr[`C16_DL_AW-1:`C16_ROM_AW];
	assign wr_addr = dl_i.addr[`C16_ROM_AW-1:0];
	assign rd_addr = cpu_addr_i[`C16_ROM_AW-1:0];
	assign is_rom  = (dl_i.index == `C16_DL_ROM);
	assign is_crt  = (dl_i.index == `C16_DL_CRT);

	////////////////////////////////////////
	// Download write enables
	always_comb begin
		wr_sel = '0;
		if (dl_i.wr && is_rom) begin
			wr_sel[`C16_ROM_KERNAL] = (dl_bank == `C16_DL_BANK_KERNAL);
			wr_sel[`C16_ROM_BASIC]  = (dl_bank == `C16_DL_BANK_BASIC);
			wr_sel[`C16_ROM_FUNC_L] = (dl_bank == `C16_DL_BANK_FUNC_L);
			wr_sel[`C16_ROM_FUNC_H] = (dl_bank == `C16_DL_BANK_FUNC_H);
		end
		if (dl_i.wr && is_crt) begin
			wr_sel[`C16_ROM_CART_L] = (dl_bank == `C16_DL_BANK_CART_L);
			wr_sel[`C16_ROM_CART_H] = (dl_bank == `C16_DL_BANK_CART_H);
		end
	end

	////////////////////////////////////////
	// One bank array per ROM
	for (genvar g = 0; g < `C16_ROM_COUNT; g++) begin : g_rom
		byte_t mem [`C16_ROM_DEPTH];
		byte_t q;

		always_ff @(posedge clk_sys) begin
			if (wr_sel[g])
				mem[wr_addr] <= dl_i.data;
			if (rom_sel_i[g])
				q <= mem[rd_addr];
			else
				q <= 8'hFF;
		end

		assign rom_q_all[g*8 +: 8] = q;
	end

	// At most one array is selected, the rest read FF
	always_comb begin
		dout_o = 8'hFF;
		for (int i = 0; i < `C16_ROM_COUNT; i++) begin
			dout_o = dout_o & rom_q_all[i*8 +: 8];
		end
	end

endmodule

`default_nettype wire

// File: src/rom_bank_ctrl.sv
// Model is sampled only during reset; bank register writes take effect only on the Plus/4
`default_nettype none

`include "c16_settings.svh"

module rom_bank_ctrl
	import c16_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     model_i,
	input  dl_port_t dl_i,
	input  cpu_bus_t cpu_i,
	output rom_sel_t rom_sel_o
);

	logic      plus4;
	logic      cs_io_old;
	rom_bank_e bank_lo;
	rom_bank_e bank_hi;
	logic      cart_l;
	logic      cart_h;
	logic      crt_dl;
	logic      bank_wr;
	logic      kern;
	logic [`C16_DL_AW-`C16_ROM_AW-1:0] dl_bank;

	assign dl_bank = dl_i.addr[`C16_DL_AW-1:`C16_ROM_AW];
	assign crt_dl  = (dl_i.index == `C16_DL_CRT);
	assign kern    = (cpu_i.addr[15:8] == `C16_KERN_PAGE);

	// Write cycle that opens the bank register
	assign bank_wr = plus4 && cs_io_old && !cpu_i.cs_io_n && !cpu_i.rnw &&
		(cpu_i.addr[15:4] == `C16_BANK_IO_PAGE);

	always_ff @(posedge clk_sys) begin
		if (reset)
			plus4 <= model_i;
	end

	////////////////////////////////////////
	// Bank register and cartridge flags
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cs_io_old <= 1'b1;
			bank_lo   <= BANK_INTERNAL;
			bank_hi   <= BANK_INTERNAL;
			cart_l    <= 1'b0;
			cart_h    <= 1'b0;
		end else begin
			cs_io_old <= cpu_i.cs_io_n;
			// A cartridge download on the Plus/4 restarts with internal ROMs
			if (plus4 && dl_i.download && crt_dl) begin
				bank_lo <= BANK_INTERNAL;
				bank_hi <= BANK_INTERNAL;
			end else if (bank_wr) begin
				bank_lo <= rom_bank_e'(cpu_i.addr[1:0]);
				bank_hi <= rom_bank_e'(cpu_i.addr[3:2]);
			end
			if (dl_i.wr && crt_dl && (dl_bank == `C16_DL_BANK_CART_L))
				cart_l <= 1'b1;
			if (dl_i.wr && crt_dl && (dl_bank == `C16_DL_BANK_CART_H))
				cart_h <= 1'b1;
		end
	end

	////////////////////////////////////////
	// ROM read select decode
	always_comb begin
		rom_sel_o = '0;
		if (!cpu_i.cs0_n) begin
			rom_sel_o[`C16_ROM_BASIC]  = (bank_lo == BANK_INTERNAL);
			rom_sel_o[`C16_ROM_CART_L] = (bank_lo == BANK_CART) && cart_l;
			rom_sel_o[`C16_ROM_FUNC_L] = (bank_lo == BANK_FUNC);
		end
		if (!cpu_i.cs1_n) begin
			// Kernal page stays visible whatever the high bank
			rom_sel_o[`C16_ROM_KERNAL] = kern || (bank_hi == BANK_INTERNAL);
			rom_sel_o[`C16_ROM_CART_H] = !kern && (bank_hi == BANK_CART) && cart_h;
			rom_sel_o[`C16_ROM_FUNC_H] = !kern && (bank_hi == BANK_FUNC);
		end
	end

endmodule

`default_nettype wire

// File: src/main_ram.sv
// Loader and CPU writes to one address in the same cycle leave the CPU byte; read-during-write gives old data
`default_nettype none

`include "c16_settings.svh"

module main_ram
	import c16_mem_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      ram_wr_i,
	input  cpu_addr_t ram_addr_i,
	input  byte_t     ram_data_i,
	input  cpu_bus_t  cpu_i,
	output byte_t     dout_o
);

	byte_t mem [`C16_RAM_DEPTH];
	logic  cs_ram_old;
	logic  cpu_we;

	////////////////////////////////////////
	// CPU write strobe
	// One strobe per select, on the falling edge of cs_ram_n
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cs_ram_old <= 1'b1;
			cpu_we     <= 1'b0;
		end else begin
			cs_ram_old <= cpu_i.cs_ram_n;
			cpu_we     <= cs_ram_old && !cpu_i.cs_ram_n && !cpu_i.rnw;
		end
	end

	////////////////////////////////////////
	// Memory array
	always_ff @(posedge clk_sys) begin
		// Port A, program loader
		if (ram_wr_i)
			mem[ram_addr_i] <= ram_data_i;

		// Port B, CPU uses address and data still held on the bus
		if (cpu_we)
			mem[cpu_i.addr] <= cpu_i.data;

		// Idle read drives ones for the AND combine
		if (cpu_i.cs_ram_n)
			dout_o <= 8'hFF;
		else
			dout_o <= mem[cpu_i.addr];
	end

endmodule

`default_nettype wire

// File: src/prg_loader.sv
// Expects PRG bytes in address order with a two-byte load header and no wait states from the host
`default_nettype none

`include "c16_settings.svh"

module prg_loader
	import c16_mem_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  dl_port_t  dl_i,
	output logic      ram_wr_o,
	output cpu_addr_t ram_addr_o,
	output byte_t     ram_data_o
);

	loader_state_e state;
	cpu_addr_t     load_addr;
	logic [3:0]    patch_cnt;
	cpu_addr_t     patch_addr;
	logic          is_prg;
	logic          prg_active;
	logic          data_wr;
	logic          patch_wr;

	assign is_prg     = (dl_i.index == `C16_DL_PRG);
	assign prg_active = dl_i.download && is_prg;

	// Bytes past the two header bytes go to RAM
	assign data_wr  = prg_active && dl_i.wr && (dl_i.addr > 1);
	assign patch_wr = (state == LOAD_PATCH) && !prg_active && !patch_cnt[0];

	// BASIC end pointers, low and high bytes interleaved
	always_comb begin
		case (patch_cnt[3:1])
			3'd0:    patch_addr = 16'h002D;
			3'd1:    patch_addr = 16'h002E;
			3'd2:    patch_addr = 16'h002F;
			3'd3:    patch_addr = 16'h0030;
			3'd4:    patch_addr = 16'h0031;
			3'd5:    patch_addr = 16'h0032;
			3'd6:    patch_addr = 16'h009D;
			default: patch_addr = 16'h009E;
		endcase
	end

	////////////////////////////////////////
	// Loader FSM
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= LOAD_IDLE;
			ram_wr_o  <= 1'b0;
			patch_cnt <= '0;
		end else begin
			ram_wr_o <= data_wr || patch_wr;
			case (state)
				LOAD_IDLE: begin
					if (prg_active)
						state <= LOAD_DATA;
				end
				LOAD_DATA: begin
					// Falling download level ends the transfer
					if (!dl_i.download) begin
						state     <= is_prg ? LOAD_PATCH : LOAD_IDLE;
						patch_cnt <= '0;
					end
				end
				LOAD_PATCH: begin
					if (prg_active) begin
						state <= LOAD_DATA;
					end else begin
						patch_cnt <= patch_cnt + 4'd1;
						if (patch_cnt == 4'd15)
							state <= LOAD_IDLE;
					end
				end
				default: state <= LOAD_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Load address and RAM write payload
	always_ff @(posedge clk_sys) begin
		if (prg_active && dl_i.wr) begin
			if (dl_i.addr == 0)
				load_addr[7:0] <= dl_i.data;
			else if (dl_i.addr == 1)
				load_addr[15:8] <= dl_i.data;
			else
				load_addr <= load_addr + 16'd1;
		end

		if (data_wr) begin
			ram_addr_o <= load_addr;
			ram_data_o <= dl_i.data;
		end else if (patch_wr) begin
			// load_addr now holds the end address
			ram_addr_o <= patch_addr;
			ram_data_o <= patch_cnt[1] ? load_addr[15:8] : load_addr[7:0];
		end
	end

endmodule

`default_nettype wire

// File: src/c16_mem_pkg.sv
// Types shared by the memory blocks; bus fields follow the host download port and the TED bus
`default_nettype none

`include "c16_settings.svh"

package c16_mem_pkg;

	typedef logic [`C16_RAM_AW-1:0]    cpu_addr_t;
	typedef logic [7:0]                byte_t;
	typedef logic [`C16_ROM_AW-1:0]    rom_addr_t;
	typedef logic [`C16_DL_AW-1:0]     dl_addr_t;
	typedef logic [`C16_ROM_COUNT-1:0] rom_sel_t;

	// Code of one ROM half, as written to the bank register
	typedef enum logic [1:0] {
		BANK_INTERNAL = 2'd0,
		BANK_CART     = 2'd1,
		BANK_FUNC     = 2'd2,
		BANK_NONE     = 2'd3
	} rom_bank_e;

	typedef enum logic [1:0] {
		LOAD_IDLE,
		LOAD_DATA,
		LOAD_PATCH
	} loader_state_e;

	// Host download port
	typedef struct packed {
		logic     download;
		byte_t    index;
		logic     wr;
		dl_addr_t addr;
		byte_t    data;
	} dl_port_t;

	// CPU side bus, selects are active low
	typedef struct packed {
		cpu_addr_t addr;
		byte_t     data;
		logic      rnw;
		logic      cs_ram_n;
		logic      cs0_n;
		logic      cs1_n;
		logic      cs_io_n;
	} cpu_bus_t;

endpackage

`default_nettype wire

// File: include/c16_settings.svh
// Widths and codes follow the C16/Plus4 download host; change them only together with the host side
`ifndef C16_SETTINGS_SVH
`define C16_SETTINGS_SVH

// Bus and memory widths
`define C16_RAM_AW        16
`define C16_ROM_AW        14
`define C16_DL_AW         25
`define C16_RAM_DEPTH     (1 << `C16_RAM_AW)
`define C16_ROM_DEPTH     (1 << `C16_ROM_AW)

// Download index codes
`define C16_DL_ROM        8'h03
`define C16_DL_PRG        8'h01
`define C16_DL_CRT        8'h81

// Bank numbers carried in download address bits 24..14
`define C16_DL_BANK_KERNAL 1
`define C16_DL_BANK_BASIC  2
`define C16_DL_BANK_FUNC_L 3
`define C16_DL_BANK_FUNC_H 4
`define C16_DL_BANK_CART_L 0
`define C16_DL_BANK_CART_H 1

// I/O page of the Plus/4 bank register and the fixed kernal page
`define C16_BANK_IO_PAGE  12'hFDD
`define C16_KERN_PAGE     8'hFC

// Bit positions in the one-hot ROM select
`define C16_ROM_COUNT     6
`define C16_ROM_KERNAL    0
`define C16_ROM_BASIC     1
`define C16_ROM_FUNC_L    2
`define C16_ROM_FUNC_H    3
`define C16_ROM_CART_L    4
`define C16_ROM_CART_H    5

`endif
